// ==== verilog/synth_pkg.sv ====
package synth_pkg;

    localparam int VOICES     = 4;                    // fixed by the register map
    localparam int VOICE_W    = 2;                    // voice index width
    localparam int SAMPLE_DIV = 16;                   // audio_clk cycles per sample
    localparam int DIV_W      = $clog2(SAMPLE_DIV);   // sample period counter width
    localparam int AUD_BITS   = 16;                   // voice sample and output width
    localparam int MIX_BITS   = 18;                   // room for four full-scale voices

    localparam logic [6:0] ATTEN_ADR = 7'h40;         // global attenuation register

    // envelope of one voice
    typedef enum logic [1:0] {
        ENV_IDLE    = 2'd0,
        ENV_HOLD    = 2'd1,
        ENV_RELEASE = 2'd2
    } env_state_e;

    // field select, adr[1:0] of a voice register
    typedef enum logic [1:0] {
        REG_PITCH_LO = 2'd0,
        REG_PITCH_HI = 2'd1,
        REG_RELEASE  = 2'd2,
        REG_RSVD     = 2'd3
    } reg_field_e;

endpackage

// ==== verilog/voice_control.sv ====
`timescale 1ns/1ps

module voice_control import synth_pkg::*; (
    input  wire                    audio_clk,
    input  wire                    arst_n,
    // note events
    input  wire                    note_on,
    input  wire                    note_off,
    input  wire  [VOICE_W-1:0]     note_voice,
    input  wire  [7:0]             note_vel,
    // register port
    input  wire                    write,
    input  wire  [6:0]             adr,
    input  wire  [7:0]             data_in,
    output logic [7:0]             data_out,
    // to the voices
    output logic [VOICES-1:0]      voice_on,
    output logic [VOICES-1:0]      voice_off,
    output logic [7:0]             vel,
    output logic [VOICES*16-1:0]   pitch_inc,
    output logic [VOICES*8-1:0]    release_step,
    // to the mixer
    output logic [1:0]             atten,
    output logic                   sample_tick
);

    logic [7:0]         pitch_lo [VOICES];
    logic [7:0]         pitch_hi [VOICES];
    logic [7:0]         rel_step [VOICES];
    logic [VOICE_W-1:0] reg_voice;
    reg_field_e         reg_field;
    logic               voice_reg;          // adr hits the voice register block
    logic [DIV_W-1:0]   div_cnt;

    assign reg_voice = adr[VOICE_W+1:2];
    assign reg_field = reg_field_e'(adr[1:0]);
    assign voice_reg = (adr[6:VOICE_W+2] == '0);

    // register file
    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < VOICES; i++) begin
                pitch_lo[i] <= '0;
                pitch_hi[i] <= '0;
                rel_step[i] <= '0;
            end
            atten <= '0;
        end else if (write) begin
            if (adr == ATTEN_ADR) begin
                atten <= data_in[1:0];          // upper bits dropped
            end else if (voice_reg) begin
                case (reg_field)
                    REG_PITCH_LO: pitch_lo[reg_voice] <= data_in;
                    REG_PITCH_HI: pitch_hi[reg_voice] <= data_in;
                    REG_RELEASE:  rel_step[reg_voice] <= data_in;
                    default: ;                  // reserved, not stored
                endcase
            end
        end
    end

    // readback, combinational from adr
    always_comb begin
        data_out = '0;
        if (adr == ATTEN_ADR) begin
            data_out = {6'b0, atten};
        end else if (voice_reg) begin
            case (reg_field)
                REG_PITCH_LO: data_out = pitch_lo[reg_voice];
                REG_PITCH_HI: data_out = pitch_hi[reg_voice];
                REG_RELEASE:  data_out = rel_step[reg_voice];
                default:      data_out = '0;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < VOICES; i++) begin
            pitch_inc[i*16 +: 16]  = {pitch_hi[i], pitch_lo[i]};
            release_step[i*8 +: 8] = rel_step[i];
        end
    end

    // note strobes to one-hot, note_on has priority
    always_comb begin
        voice_on  = '0;
        voice_off = '0;
        if (note_on) begin
            voice_on[note_voice] = 1'b1;
        end else if (note_off) begin
            voice_off[note_voice] = 1'b1;
        end
    end

    assign vel = note_vel;

    // sample period, first tick SAMPLE_DIV cycles out of reset
    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= (div_cnt == DIV_W'(SAMPLE_DIV - 1));
            div_cnt     <= div_cnt + 1'b1;      // wraps at SAMPLE_DIV
        end
    end

endmodule

// ==== verilog/synth_voice.sv ====
`timescale 1ns/1ps

module synth_voice import synth_pkg::*; (
    input  wire                        audio_clk,
    input  wire                        arst_n,
    input  wire                        sample_tick,
    input  wire                        voice_on,
    input  wire                        voice_off,
    input  wire         [7:0]          vel,
    input  wire         [15:0]         pitch_inc,
    input  wire         [7:0]          release_step,
    output logic signed [AUD_BITS-1:0] sample,
    output logic                       voice_free
);

    env_state_e           state;
    env_state_e           state_nxt;
    logic [7:0]           level;
    logic [7:0]           level_nxt;
    logic [15:0]          phase;
    logic [15:0]          phase_nxt;
    logic signed [7:0]    saw;              // upper phase byte minus 128
    logic signed [AUD_BITS-1:0] product;

    always_comb begin
        state_nxt = state;
        level_nxt = level;
        phase_nxt = phase;
        if (voice_on) begin
            state_nxt = ENV_HOLD;
            level_nxt = vel;
            phase_nxt = '0;
        end else begin
            if (voice_off && state == ENV_HOLD) begin
                state_nxt = ENV_RELEASE;
            end
            if (sample_tick && state != ENV_IDLE) begin
                phase_nxt = phase + pitch_inc;  // wraps
                if (state == ENV_RELEASE) begin
                    if (level <= release_step) begin
                        level_nxt = '0;         // saturate, voice done
                        state_nxt = ENV_IDLE;
                    end else begin
                        level_nxt = level - release_step;
                    end
                end
            end
        end
    end

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ENV_IDLE;
            level <= '0;
            phase <= '0;
        end else begin
            state <= state_nxt;
            level <= level_nxt;
            phase <= phase_nxt;
        end
    end

    // offset binary to two's complement by flipping the msb
    assign saw     = $signed({~phase_nxt[15], phase_nxt[14:8]});
    assign product = AUD_BITS'(saw) * AUD_BITS'($signed({1'b0, level_nxt}));

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= '0;
        end else if (sample_tick) begin
            sample <= product;                  // always fits, |saw*level| < 2^15
        end
    end

    assign voice_free = (state == ENV_IDLE);

endmodule

// ==== verilog/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer import synth_pkg::*; (
    input  wire                          audio_clk,
    input  wire                          arst_n,
    input  wire                          sample_tick,
    input  wire  [VOICES*AUD_BITS-1:0]   samples,
    input  wire  [1:0]                   atten,
    output logic signed [AUD_BITS-1:0]   audio_out,
    output logic                         sample_valid
);

    logic                       tick_d;     // voice samples settled
    logic signed [MIX_BITS-1:0] sum;
    logic signed [MIX_BITS-1:0] scaled;
    logic signed [AUD_BITS-1:0] clipped;
    logic                       in_range;

    always_comb begin
        sum = '0;
        for (int i = 0; i < VOICES; i++) begin
            sum = sum + MIX_BITS'($signed(samples[i*AUD_BITS +: AUD_BITS]));
        end
    end

    assign scaled = sum >>> atten;

    // in range when all bits above the output msb match the sign
    assign in_range = (scaled[MIX_BITS-1:AUD_BITS-1] == '0) ||
                      (scaled[MIX_BITS-1:AUD_BITS-1] == '1);

    always_comb begin
        if (in_range) begin
            clipped = scaled[AUD_BITS-1:0];
        end else if (scaled[MIX_BITS-1]) begin
            clipped = {1'b1, {(AUD_BITS-1){1'b0}}};     // negative full scale
        end else begin
            clipped = {1'b0, {(AUD_BITS-1){1'b1}}};     // positive full scale
        end
    end

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_d       <= 1'b0;
            sample_valid <= 1'b0;
            audio_out    <= '0;
        end else begin
            tick_d       <= sample_tick;
            sample_valid <= tick_d;             // one cycle pulse
            if (tick_d) begin
                audio_out <= clipped;
            end
        end
    end

endmodule

// ==== verilog/synth_engine.sv ====
`timescale 1ns/1ps

module synth_engine import synth_pkg::*; (
    input  wire                          audio_clk,
    input  wire                          arst_n,
    input  wire                          note_on,
    input  wire                          note_off,
    input  wire  [VOICE_W-1:0]           note_voice,
    input  wire  [7:0]                   note_vel,
    input  wire                          write,
    input  wire  [6:0]                   adr,
    input  wire  [7:0]                   data_in,
    output logic [7:0]                   data_out,
    output logic signed [AUD_BITS-1:0]   audio_out,
    output logic                         sample_valid,
    output logic [VOICES-1:0]            voice_free
);

    logic [VOICES-1:0]          voice_on;
    logic [VOICES-1:0]          voice_off;
    logic [7:0]                 vel;
    logic [VOICES*16-1:0]       pitch_inc;
    logic [VOICES*8-1:0]        release_step;
    logic [1:0]                 atten;
    logic                       sample_tick;
    logic [VOICES*AUD_BITS-1:0] samples;    // voice samples, voice 0 in the low bits

    voice_control i_voice_control (
        .audio_clk    ( audio_clk ),
        .arst_n       ( arst_n ),
        .note_on      ( note_on ),
        .note_off     ( note_off ),
        .note_voice   ( note_voice ),
        .note_vel     ( note_vel ),
        .write        ( write ),
        .adr          ( adr ),
        .data_in      ( data_in ),
        .data_out     ( data_out ),
        .voice_on     ( voice_on ),
        .voice_off    ( voice_off ),
        .vel          ( vel ),
        .pitch_inc    ( pitch_inc ),
        .release_step ( release_step ),
        .atten        ( atten ),
        .sample_tick  ( sample_tick )
    );

    for (genvar v = 0; v < VOICES; v++) begin : g_voice
        synth_voice i_synth_voice (
            .audio_clk    ( audio_clk ),
            .arst_n       ( arst_n ),
            .sample_tick  ( sample_tick ),
            .voice_on     ( voice_on[v] ),
            .voice_off    ( voice_off[v] ),
            .vel          ( vel ),
            .pitch_inc    ( pitch_inc[v*16 +: 16] ),
            .release_step ( release_step[v*8 +: 8] ),
            .sample       ( samples[v*AUD_BITS +: AUD_BITS] ),
            .voice_free   ( voice_free[v] )
        );
    end

    voice_mixer i_voice_mixer (
        .audio_clk    ( audio_clk ),
        .arst_n       ( arst_n ),
        .sample_tick  ( sample_tick ),
        .samples      ( samples ),
        .atten        ( atten ),
        .audio_out    ( audio_out ),
        .sample_valid ( sample_valid )
    );

endmodule

// ==== verif/synth_tb.sv ====
`timescale 1ns/1ps

module synth_tb import synth_pkg::*; ();

    localparam int CLK_NS       = 10;
    localparam int TONE_SAMPLES = 12;
    localparam int TEST_PERIODS = 70;                       // all tests, rounded up
    localparam int WATCHDOG_NS  = (TEST_PERIODS + 20) * SAMPLE_DIV * CLK_NS;
    localparam int FULL_POS     = (1 << (AUD_BITS - 1)) - 1;
    localparam int FULL_NEG     = -(1 << (AUD_BITS - 1));

    logic                       audio_clk;
    logic                       arst_n;
    logic                       note_on;
    logic                       note_off;
    logic [VOICE_W-1:0]         note_voice;
    logic [7:0]                 note_vel;
    logic                       write;
    logic [6:0]                 adr;
    logic [7:0]                 data_in;
    logic [7:0]                 data_out;
    logic signed [AUD_BITS-1:0] audio_out;
    logic                       sample_valid;
    logic [VOICES-1:0]          voice_free;

    logic [31:0] lfsr_state = 32'ha0102318;
    logic [15:0] m_phase [VOICES];                          // reference model per voice
    logic [7:0]  m_level [VOICES];
    env_state_e  m_state [VOICES];
    logic [7:0]  m_regs  [16];                              // expected voice register readback
    logic [1:0]  m_atten;
    int          tone_voice;

    synth_engine i_dut (
        .audio_clk    ( audio_clk ),
        .arst_n       ( arst_n ),
        .note_on      ( note_on ),
        .note_off     ( note_off ),
        .note_voice   ( note_voice ),
        .note_vel     ( note_vel ),
        .write        ( write ),
        .adr          ( adr ),
        .data_in      ( data_in ),
        .data_out     ( data_out ),
        .audio_out    ( audio_out ),
        .sample_valid ( sample_valid ),
        .voice_free   ( voice_free )
    );

    initial begin
        audio_clk = 1'b0;
        forever #(CLK_NS / 2) audio_clk = ~audio_clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input logic signed [AUD_BITS-1:0] act,
                                input logic signed [AUD_BITS-1:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_free(input string name, input logic [VOICES-1:0] act,
                              input logic [VOICES-1:0] exp);
        if (act !== exp) begin
            stop_run($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    // saw is the upper phase byte taken as offset binary
    function automatic int voice_value(input int v);
        return (int'(m_phase[v][15:8]) - 128) * int'(m_level[v]);
    endfunction

    function automatic logic signed [AUD_BITS-1:0] expected_mix();
        int sum;
        sum = 0;
        for (int v = 0; v < VOICES; v++) begin
            sum += voice_value(v);
        end
        sum = sum >>> m_atten;
        if (sum > FULL_POS) begin
            sum = FULL_POS;
        end else if (sum < FULL_NEG) begin
            sum = FULL_NEG;
        end
        return AUD_BITS'(sum);
    endfunction

    function automatic logic [VOICES-1:0] free_flags();
        logic [VOICES-1:0] f;
        for (int v = 0; v < VOICES; v++) begin
            f[v] = (m_state[v] == ENV_IDLE);
        end
        return f;
    endfunction

    // one sample period of every voice
    task automatic step_model();
        int lvl;
        for (int v = 0; v < VOICES; v++) begin
            if (m_state[v] != ENV_IDLE) begin
                m_phase[v] = m_phase[v] + {m_regs[4*v+1], m_regs[4*v]};
                if (m_state[v] == ENV_RELEASE) begin
                    lvl = int'(m_level[v]) - int'(m_regs[4*v+2]);
                    m_level[v] = (lvl > 0) ? 8'(lvl) : 8'h00;
                    if (lvl <= 0) begin
                        m_state[v] = ENV_IDLE;
                    end
                end
            end
        end
    endtask

    task automatic write_reg(input logic [6:0] a, input logic [7:0] d);
        @(posedge audio_clk);
        write   <= 1'b1;
        adr     <= a;
        data_in <= d;
        @(posedge audio_clk);
        write <= 1'b0;
        if (a == ATTEN_ADR) begin
            m_atten = d[1:0];
        end else if (a < 7'd16 && reg_field_e'(a[1:0]) != REG_RSVD) begin
            m_regs[a[3:0]] = d;
        end
    endtask

    task automatic read_check(input logic [6:0] a, input logic [7:0] exp);
        @(posedge audio_clk);
        adr <= a;
        @(negedge audio_clk);
        check_byte("data_out", data_out, exp);
    endtask

    task automatic send_note(input logic on, input int v, input logic [7:0] vl);
        @(posedge audio_clk);
        note_on    <= on;
        note_off   <= !on;
        note_voice <= VOICE_W'(v);
        note_vel   <= vl;
        @(posedge audio_clk);
        note_on  <= 1'b0;
        note_off <= 1'b0;
        if (on) begin
            m_phase[v] = '0;
            m_level[v] = vl;
            m_state[v] = ENV_HOLD;
        end else if (m_state[v] == ENV_HOLD) begin
            m_state[v] = ENV_RELEASE;
        end
    endtask

    // next output sample, model stepped before the compare
    task automatic wait_sample();
        int n;
        n = 0;
        @(negedge audio_clk);
        while (!sample_valid) begin
            n++;
            if (n > 2 * SAMPLE_DIV) begin
                stop_run("sample_valid did not pulse within two sample periods");
            end
            @(negedge audio_clk);
        end
        step_model();
        check_sample("audio_out", audio_out, expected_mix());
        check_free("voice_free", voice_free, free_flags());
    endtask

    task automatic test_reset();
        for (int i = 0; i < SAMPLE_DIV; i++) begin
            @(negedge audio_clk);
            if (sample_valid) begin
                stop_run("sample_valid pulsed inside the first sample period after reset");
            end
            check_free("voice_free", voice_free, '1);
            check_sample("audio_out", audio_out, '0);
        end
    endtask

    task automatic test_registers();
        for (int a = 0; a < 16; a++) begin
            write_reg(7'(a), 8'(rand_bits(8)));
        end
        write_reg(ATTEN_ADR, 8'(rand_bits(8)));
        for (int a = 0; a < 16; a++) begin
            read_check(7'(a), m_regs[a]);                   // reserved fields stay 0
        end
        read_check(ATTEN_ADR, {6'b0, m_atten});
        read_check(7'h20, 8'h00);                           // unmapped
        read_check(7'h7f, 8'h00);
    endtask

    task automatic test_tone();
        logic [15:0] pitch;
        logic [7:0]  vl;
        tone_voice = int'(rand_bits(VOICE_W));
        pitch      = 16'(rand_bits(16)) | 16'h0100;
        vl         = 8'(rand_bits(8)) | 8'h80;
        wait_sample();
        write_reg(7'(4 * tone_voice), pitch[7:0]);
        write_reg(7'(4 * tone_voice + 1), pitch[15:8]);
        send_note(1'b1, tone_voice, vl);
        @(negedge audio_clk);
        check_free("voice_free", voice_free, free_flags());
        repeat (TONE_SAMPLES) wait_sample();
    endtask

    task automatic test_release();
        wait_sample();
        write_reg(7'(4 * tone_voice + 2), 8'(rand_bits(8)) | 8'h10);    // at most 16 steps
        send_note(1'b0, tone_voice, 8'h00);
        while (m_state[tone_voice] != ENV_IDLE) begin
            wait_sample();
        end
        repeat (2) wait_sample();
        check_sample("audio_out", audio_out, '0);
    endtask

    task automatic test_polyphony();
        logic [15:0] pitch;
        int          clips;
        pitch = 16'(rand_bits(16)) | 16'h0100;              // shared, voices stay in phase
        clips = 0;
        for (int v = 0; v < VOICES; v++) begin
            write_reg(7'(4 * v), pitch[7:0]);
            write_reg(7'(4 * v + 1), pitch[15:8]);
        end
        write_reg(ATTEN_ADR, 8'h00);
        wait_sample();
        for (int v = 0; v < VOICES; v++) begin
            send_note(1'b1, v, 8'hff);
        end
        repeat (TONE_SAMPLES) begin
            wait_sample();
            if (audio_out == AUD_BITS'(FULL_POS) || audio_out == AUD_BITS'(FULL_NEG)) begin
                clips++;
            end
        end
        if (clips == 0) begin
            stop_run("four full scale voices never drove the output to its limit");
        end
        write_reg(ATTEN_ADR, 8'h02);
        repeat (TONE_SAMPLES) wait_sample();
    endtask

    initial begin
        arst_n     = 1'b0;
        note_on    = 1'b0;
        note_off   = 1'b0;
        note_voice = '0;
        note_vel   = '0;
        write      = 1'b0;
        adr        = '0;
        data_in    = '0;
        m_atten    = '0;
        tone_voice = 0;
        for (int v = 0; v < VOICES; v++) begin
            m_phase[v] = '0;
            m_level[v] = '0;
            m_state[v] = ENV_IDLE;
        end
        for (int a = 0; a < 16; a++) begin
            m_regs[a] = '0;
        end
        repeat (2) @(posedge audio_clk);
        arst_n <= 1'b1;
        test_reset();
        test_registers();
        test_tone();
        test_release();
        test_polyphony();
        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("timeout, the tests did not finish in time");
    end

endmodule

// ==== tb.f ====
verilog/synth_pkg.sv
verilog/voice_control.sv
verilog/synth_voice.sv
verilog/voice_mixer.sv
verilog/synth_engine.sv
verif/synth_tb.sv

// ==== Makefile ====
TOP := synth_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -f tb.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
